// File: rtl/isa_pkg.sv
// ISA definitions for the decode stage
package isa_pkg;

	// 5-bit operation codes, 23 to 30 are unassigned
	typedef enum logic [4:0] {
		ADD  = 5'd0,
		ADDI = 5'd1,
		SUB  = 5'd2,
		SUBI = 5'd3,
		AND  = 5'd4,
		OR   = 5'd5,
		XOR  = 5'd6,
		NEG  = 5'd7,
		SLL  = 5'd8,
		SLR  = 5'd9,
		SAR  = 5'd10,
		LD   = 5'd11,
		LDI  = 5'd12,
		ST   = 5'd13,
		STI  = 5'd14,
		NOP  = 5'd15,
		BEQ  = 5'd16,
		BNE  = 5'd17,
		BON  = 5'd18,
		BNN  = 5'd19,
		J    = 5'd20,
		JR   = 5'd21,
		JAL  = 5'd22,
		RIN  = 5'd31
	} opcode_e;

	// registers that the register file never writes
	localparam logic [4:0] REG_ZERO = 5'd0;
	localparam logic [4:0] REG_LR   = 5'd30;
	localparam logic [4:0] REG_FL   = 5'd31;

	// instruction memory starts here, upper half of jump targets
	localparam logic [15:0] INSTR_BASE = 16'h0600;

	// control bundle for execute, memory and writeback, 23 bits
	typedef struct packed {
		logic [1:0] alu_src;
		opcode_e    alu_op;
		logic       branch;
		logic       jump;
		logic       mem_wrt;
		logic       mem_en;
		logic [1:0] result_sel;
		logic       reg_wrt_en;
		logic [4:0] reg_wrt_sel;
		logic       lr_read;
		logic       lr_write;
		logic       fl_read;
		logic       fl_write;
	} ctrl_t;

	// payload held in the ID/EX register
	typedef struct packed {
		logic [31:0] pc_next;
		logic [31:0] reg_1_data;
		logic [31:0] reg_2_data;
		logic [31:0] imm;
		logic [31:0] lr;
		logic [1:0]  fl;
		ctrl_t       ctrl;
	} id_ex_t;

	// register write coming back from writeback
	typedef struct packed {
		logic        wrt_en;
		logic [4:0]  wrt_sel;
		logic [31:0] wrt_data;
	} wb_t;

	// LR and FL updates, including the interrupt restore copies
	typedef struct packed {
		logic        lr_write;
		logic [31:0] lr_data;
		logic        fl_write;
		logic [1:0]  fl_data;
		logic        restore;
		logic [31:0] lr_saved;
		logic [1:0]  fl_saved;
	} spec_wr_t;

	// inactive control bundle, register source with a NOP op
	localparam ctrl_t CTRL_NOP = '{
		alu_src:     2'd1,
		alu_op:      NOP,
		branch:      1'b0,
		jump:        1'b0,
		mem_wrt:     1'b0,
		mem_en:      1'b0,
		result_sel:  2'd0,
		reg_wrt_en:  1'b0,
		reg_wrt_sel: 5'd0,
		lr_read:     1'b0,
		lr_write:    1'b0,
		fl_read:     1'b0,
		fl_write:    1'b0
	};

	// empty pipeline entry, loaded at reset and on flush
	localparam id_ex_t ID_EX_NOP = '{
		pc_next:    32'd0,
		reg_1_data: 32'd0,
		reg_2_data: 32'd0,
		imm:        32'd0,
		lr:         32'd0,
		fl:         2'd0,
		ctrl:       CTRL_NOP
	};

endpackage

// File: rtl/reg_file_bypass.sv
// Register file with write-through bypass
`timescale 1ns/1ns

module reg_file_bypass (
	input  logic         clk,
	input  logic         rst_n,
	input  logic [4:0]   read_1_sel,
	input  logic [4:0]   read_2_sel,
	input  isa_pkg::wb_t wb,
	output logic [31:0]  read_1_data,
	output logic [31:0]  read_2_data
);

	logic [31:0] regs [32];
	logic        wrt_legal;

	// r0, LR and FL slots are never written, so they read back as zero
	assign wrt_legal = wb.wrt_en &&
		(wb.wrt_sel != isa_pkg::REG_ZERO) &&
		(wb.wrt_sel != isa_pkg::REG_LR) &&
		(wb.wrt_sel != isa_pkg::REG_FL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wrt_legal) begin
			regs[wb.wrt_sel] <= wb.wrt_data;
		end
	end

	// same-cycle write is forwarded to either port
	always_comb begin
		if (wrt_legal && (read_1_sel == wb.wrt_sel)) begin
			read_1_data = wb.wrt_data;
		end else begin
			read_1_data = regs[read_1_sel];
		end
	end

	always_comb begin
		if (wrt_legal && (read_2_sel == wb.wrt_sel)) begin
			read_2_data = wb.wrt_data;
		end else begin
			read_2_data = regs[read_2_sel];
		end
	end

endmodule

// File: rtl/special_regs.sv
// Link and flag registers
`timescale 1ns/1ns

module special_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  isa_pkg::spec_wr_t spec,
	output logic [31:0]       lr,
	output logic [1:0]        fl
);

	logic [31:0] lr_next;
	logic [1:0]  fl_next;

	// interrupt return puts back the copies saved on entry
	always_comb begin
		if (spec.restore) begin
			lr_next = spec.lr_saved;
			fl_next = spec.fl_saved;
		end else begin
			lr_next = spec.lr_write ? spec.lr_data : lr;
			fl_next = spec.fl_write ? spec.fl_data : fl;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lr <= 32'd0;
			fl <= 2'd0;
		end else begin
			lr <= lr_next;
			fl <= fl_next;
		end
	end

endmodule

// File: rtl/control_decoder.sv
// Instruction control decode
`timescale 1ns/1ns

module control_decoder (
	input  logic [31:0]   instr,
	output isa_pkg::ctrl_t ctrl,
	output logic [31:0]   imm
);

	isa_pkg::opcode_e op;
	logic [4:0]       src_1;
	logic [4:0]       src_2;
	logic             src_1_lr;
	logic             src_1_fl;
	logic             src_2_lr;
	logic             src_2_fl;
	logic [31:0]      imm_sext12;
	logic [31:0]      imm_zext16;
	logic [31:0]      imm_jump;

	assign op    = isa_pkg::opcode_e'(instr[31:27]);
	assign src_1 = instr[21:17];
	assign src_2 = instr[16:12];

	// source fields that name the special registers
	assign src_1_lr = (src_1 == isa_pkg::REG_LR);
	assign src_1_fl = (src_1 == isa_pkg::REG_FL);
	assign src_2_lr = (src_2 == isa_pkg::REG_LR);
	assign src_2_fl = (src_2 == isa_pkg::REG_FL);

	// immediate formats
	assign imm_sext12 = {{20{instr[11]}}, instr[11:0]};
	assign imm_zext16 = {16'h0000, instr[15:0]};
	// word index into instruction memory, made byte addressed
	assign imm_jump   = {isa_pkg::INSTR_BASE, instr[13:0], 2'b00};

	always_comb begin
		// most ops read registers and update flags
		ctrl             = '0;
		ctrl.alu_src     = 2'd1;
		ctrl.alu_op      = op;
		ctrl.fl_write    = 1'b1;
		imm              = 32'd0;

		case (op)
			// two-source ALU ops
			isa_pkg::ADD, isa_pkg::SUB, isa_pkg::AND, isa_pkg::OR,
			isa_pkg::XOR, isa_pkg::SLL, isa_pkg::SLR, isa_pkg::SAR: begin
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = instr[26:22];
				ctrl.lr_read     = src_1_lr || src_2_lr;
				ctrl.fl_read     = src_1_fl || src_2_fl;
			end

			// register and immediate
			isa_pkg::ADDI, isa_pkg::SUBI: begin
				ctrl.alu_src     = 2'd0;
				imm              = imm_sext12;
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = instr[26:22];
				ctrl.lr_read     = src_1_lr;
				ctrl.fl_read     = src_1_fl;
			end

			isa_pkg::NEG: begin
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = instr[26:22];
				ctrl.lr_read     = src_1_lr;
				ctrl.fl_read     = src_1_fl;
			end

			// loads write back from memory
			isa_pkg::LD: begin
				ctrl.mem_en      = 1'b1;
				ctrl.result_sel  = 2'd1;
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = instr[26:22];
				ctrl.lr_read     = src_1_lr;
				ctrl.fl_read     = src_1_fl;
			end

			isa_pkg::LDI: begin
				ctrl.alu_src     = 2'd0;
				imm              = imm_zext16;
				ctrl.mem_en      = 1'b1;
				ctrl.result_sel  = 2'd1;
				ctrl.reg_wrt_en  = 1'b1;
				ctrl.reg_wrt_sel = instr[26:22];
			end

			// stores leave the flags alone
			isa_pkg::ST: begin
				ctrl.mem_en   = 1'b1;
				ctrl.mem_wrt  = 1'b1;
				ctrl.lr_read  = src_1_lr;
				ctrl.fl_read  = src_1_fl;
				ctrl.fl_write = 1'b0;
			end

			isa_pkg::STI: begin
				ctrl.alu_src  = 2'd0;
				imm           = imm_zext16;
				ctrl.mem_en   = 1'b1;
				ctrl.mem_wrt  = 1'b1;
				ctrl.fl_write = 1'b0;
			end

			// conditional branches test the flags
			isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::BON, isa_pkg::BNN: begin
				ctrl.branch     = 1'b1;
				ctrl.result_sel = 2'd2;
				ctrl.lr_read    = src_1_lr;
				ctrl.fl_read    = 1'b1;
				ctrl.fl_write   = 1'b0;
			end

			isa_pkg::J, isa_pkg::JAL: begin
				ctrl.alu_src    = 2'd0;
				ctrl.jump       = 1'b1;
				imm             = imm_jump;
				ctrl.result_sel = 2'd2;
				// only JAL saves the return address
				ctrl.lr_write   = (op == isa_pkg::JAL);
				ctrl.fl_write   = 1'b0;
			end

			isa_pkg::JR: begin
				ctrl.jump       = 1'b1;
				ctrl.result_sel = 2'd2;
				ctrl.lr_read    = src_1_lr;
				ctrl.fl_read    = src_1_fl;
				ctrl.fl_write   = 1'b0;
			end

			// RIN acts like a NOP here, the interrupt logic does the restore
			isa_pkg::NOP, isa_pkg::RIN: begin
				ctrl.fl_write = 1'b0;
			end

			// unassigned codes, all ones marks the error downstream
			default: begin
				ctrl = '1;
				imm  = 32'hFFFF_FFFF;
			end
		endcase
	end

endmodule

// File: rtl/id_ex_reg.sv
// ID/EX pipeline register
`timescale 1ns/1ns

module id_ex_reg (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            flush,
	input  isa_pkg::id_ex_t d,
	output isa_pkg::id_ex_t q
);

	isa_pkg::id_ex_t q_next;

	// a flushed slot becomes a bubble with every control inactive
	always_comb begin
		if (flush) begin
			q_next = isa_pkg::ID_EX_NOP;
		end else begin
			q_next = d;
		end
	end

	// no stall input, an entry is taken every cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= isa_pkg::ID_EX_NOP;
		end else begin
			q <= q_next;
		end
	end

endmodule

// File: rtl/decode_stage.sv
// Instruction decode stage
`timescale 1ns/1ns

module decode_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [31:0]       instr,
	input  logic [31:0]       pc_next,
	input  isa_pkg::wb_t      wb,
	input  isa_pkg::spec_wr_t spec,
	input  logic              flush,
	output isa_pkg::id_ex_t   id_ex
);

	logic [31:0]     reg_1_data;
	logic [31:0]     reg_2_data;
	logic [31:0]     lr;
	logic [1:0]      fl;
	logic [31:0]     imm;
	isa_pkg::ctrl_t  ctrl;
	isa_pkg::id_ex_t id_ex_d;

	// operand reads from the two source fields
	reg_file_bypass u_reg_file (
		.clk         (clk),
		.rst_n       (rst_n),
		.read_1_sel  (instr[21:17]),
		.read_2_sel  (instr[16:12]),
		.wb          (wb),
		.read_1_data (reg_1_data),
		.read_2_data (reg_2_data)
	);

	special_regs u_special_regs (
		.clk   (clk),
		.rst_n (rst_n),
		.spec  (spec),
		.lr    (lr),
		.fl    (fl)
	);

	control_decoder u_control_decoder (
		.instr (instr),
		.ctrl  (ctrl),
		.imm   (imm)
	);

	// LR and FL go out as held before this edge
	assign id_ex_d.pc_next    = pc_next;
	assign id_ex_d.reg_1_data = reg_1_data;
	assign id_ex_d.reg_2_data = reg_2_data;
	assign id_ex_d.imm        = imm;
	assign id_ex_d.lr         = lr;
	assign id_ex_d.fl         = fl;
	assign id_ex_d.ctrl       = ctrl;

	id_ex_reg u_id_ex_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (flush),
		.d     (id_ex_d),
		.q     (id_ex)
	);

endmodule

// File: tb/decode_ref.svh
// Reference decode model
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// expected control bundle and immediate for one instruction
function automatic void ref_decode(
	input  logic [31:0]    word,
	output isa_pkg::ctrl_t c,
	output logic [31:0]    imm
);
	logic [4:0] op;
	logic [4:0] s1;
	logic [4:0] s2;
	logic       two_src;
	op = word[31:27];
	s1 = word[21:17];
	s2 = word[16:12];
	c = '0;
	c.alu_src = 2'd1;
	c.alu_op = isa_pkg::opcode_e'(op);
	c.fl_write = 1'b1;
	imm = 32'd0;
	// unassigned codes flag an error everywhere
	if (op >= 5'd23 && op <= 5'd30) begin
		c = '1;
		imm = '1;
		return;
	end
	if (op <= 5'd10) begin
		c.reg_wrt_en = 1'b1;
		c.reg_wrt_sel = word[26:22];
		// ADDI, SUBI and NEG take one source only
		two_src = !(op == 5'd1 || op == 5'd3 || op == 5'd7);
		c.lr_read = (s1 == 5'd30) || (two_src && s2 == 5'd30);
		c.fl_read = (s1 == 5'd31) || (two_src && s2 == 5'd31);
		if (op == 5'd1 || op == 5'd3) begin
			c.alu_src = 2'd0;
			imm = {{20{word[11]}}, word[11:0]};
		end
	end else if (op <= 5'd14) begin
		c.mem_en = 1'b1;
		if (op == 5'd11 || op == 5'd12) begin
			c.result_sel = 2'd1;
			c.reg_wrt_en = 1'b1;
			c.reg_wrt_sel = word[26:22];
		end else begin
			c.mem_wrt = 1'b1;
			c.fl_write = 1'b0;
		end
		if (op == 5'd12 || op == 5'd14) begin
			c.alu_src = 2'd0;
			imm = {16'h0000, word[15:0]};
		end else begin
			c.lr_read = (s1 == 5'd30);
			c.fl_read = (s1 == 5'd31);
		end
	end else if (op >= 5'd16 && op <= 5'd19) begin
		c.branch = 1'b1;
		c.result_sel = 2'd2;
		c.lr_read = (s1 == 5'd30);
		c.fl_read = 1'b1;
		c.fl_write = 1'b0;
	end else if (op >= 5'd20 && op <= 5'd22) begin
		c.jump = 1'b1;
		c.result_sel = 2'd2;
		c.fl_write = 1'b0;
		if (op == 5'd21) begin
			c.lr_read = (s1 == 5'd30);
			c.fl_read = (s1 == 5'd31);
		end else begin
			c.alu_src = 2'd0;
			imm = {isa_pkg::INSTR_BASE, word[13:0], 2'b00};
			c.lr_write = (op == 5'd22);
		end
	end else begin
		// NOP and RIN
		c.fl_write = 1'b0;
	end
endfunction

// empty pipeline entry
function automatic isa_pkg::id_ex_t ref_nop();
	isa_pkg::id_ex_t e;
	e = '0;
	e.ctrl.alu_src = 2'd1;
	e.ctrl.alu_op = isa_pkg::NOP;
	return e;
endfunction

`endif

// File: tb/tb_decode_stage.sv
// Decode stage testbench
`timescale 1ns/1ns

module tb_decode_stage;

	localparam int NUM_INSTR = 300;

	logic              clk;
	logic              rst_n;
	logic [31:0]       instr;
	logic [31:0]       pc_next;
	isa_pkg::wb_t      wb;
	isa_pkg::spec_wr_t spec;
	logic              flush;
	isa_pkg::id_ex_t   id_ex;

	// shadow copy of the architectural state
	logic [31:0] shadow_regs [32];
	logic [31:0] shadow_lr;
	logic [1:0]  shadow_fl;
	logic [31:0] rng_state;
	logic        active;
	int          checks_done;

	`include "decode_ref.svh"

	decode_stage UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.instr   (instr),
		.pc_next (pc_next),
		.wb      (wb),
		.spec    (spec),
		.flush   (flush),
		.id_ex   (id_ex)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// r0, LR and FL slots never take a write
	function automatic logic writable(input logic [4:0] sel);
		return (sel != isa_pkg::REG_ZERO) && (sel != isa_pkg::REG_LR) &&
			(sel != isa_pkg::REG_FL);
	endfunction

	function automatic logic [31:0] read_shadow(input logic [4:0] sel);
		if (wb.wrt_en && writable(wb.wrt_sel) && (wb.wrt_sel == sel)) begin
			return wb.wrt_data;
		end
		return shadow_regs[sel];
	endfunction

	function automatic isa_pkg::id_ex_t expected_entry();
		isa_pkg::id_ex_t e;
		isa_pkg::ctrl_t  c;
		logic [31:0]     imm;
		if (flush) begin
			return ref_nop();
		end
		ref_decode(instr, c, imm);
		e.pc_next = pc_next;
		e.reg_1_data = read_shadow(instr[21:17]);
		e.reg_2_data = read_shadow(instr[16:12]);
		e.imm = imm;
		e.lr = shadow_lr;
		e.fl = shadow_fl;
		e.ctrl = c;
		return e;
	endfunction

	task automatic update_shadow();
		if (wb.wrt_en && writable(wb.wrt_sel)) begin
			shadow_regs[wb.wrt_sel] = wb.wrt_data;
		end
		// restore beats both write strobes
		if (spec.restore) begin
			shadow_lr = spec.lr_saved;
			shadow_fl = spec.fl_saved;
		end else begin
			if (spec.lr_write) begin
				shadow_lr = spec.lr_data;
			end
			if (spec.fl_write) begin
				shadow_fl = spec.fl_data;
			end
		end
	endtask

	task automatic check_field(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (act === exp) else begin
			$display("[ERROR] %s expected %h actual %h", name, exp, act);
			$display("Testbench failed");
			$fatal(1, "id_ex mismatch");
		end
	endtask

	task automatic compare_entry(input isa_pkg::id_ex_t e);
		check_field("id_ex.pc_next", e.pc_next, id_ex.pc_next);
		check_field("id_ex.reg_1_data", e.reg_1_data, id_ex.reg_1_data);
		check_field("id_ex.reg_2_data", e.reg_2_data, id_ex.reg_2_data);
		check_field("id_ex.imm", e.imm, id_ex.imm);
		check_field("id_ex.lr", e.lr, id_ex.lr);
		check_field("id_ex.fl", {30'd0, e.fl}, {30'd0, id_ex.fl});
		check_field("id_ex.ctrl", {9'd0, e.ctrl}, {9'd0, id_ex.ctrl});
	endtask

	task automatic set_idle();
		instr = {5'd15, 27'd0};
		pc_next = 32'd0;
		wb = '0;
		spec = '0;
		flush = 1'b0;
	endtask

	task automatic drive_random(input int idx);
		logic [31:0] r;
		logic [31:0] ctl;
		logic [4:0]  op;
		r = next_random();
		wb.wrt_en = r[0];
		wb.wrt_sel = r[5:1];
		wb.wrt_data = next_random();
		r = next_random();
		ctl = next_random();
		// first 32 entries walk every opcode once
		op = (idx < 32) ? idx[4:0] : r[31:27];
		instr = {op, r[26:0]};
		// steer sources onto the write port to hit the bypass
		if (ctl[1:0] == 2'b00) begin
			instr[21:17] = wb.wrt_sel;
		end
		if (ctl[3:2] == 2'b00) begin
			instr[16:12] = wb.wrt_sel;
		end
		pc_next = next_random();
		spec.lr_write = (ctl[5:4] == 2'b00);
		spec.fl_write = (ctl[7:6] == 2'b00);
		spec.restore = (ctl[10:8] == 3'b000);
		spec.lr_data = next_random();
		spec.fl_data = ctl[16:15];
		spec.lr_saved = next_random();
		spec.fl_saved = ctl[18:17];
		if (idx % 50 == 25) begin
			spec.restore = 1'b1;
			spec.lr_write = 1'b1;
			spec.fl_write = 1'b1;
		end
		flush = (idx >= 32) && ((idx % 20 == 19) || (ctl[14:11] == 4'd0));
	endtask

	// expected entry is formed at the edge, checked at the next falling edge
	initial begin : compare_proc
		isa_pkg::id_ex_t exp;
		logic            exp_valid;
		int              wait_cycles;
		checks_done = 0;
		wait_cycles = 0;
		@(posedge clk);
		while (!rst_n && wait_cycles < 50) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (!rst_n) begin
			$display("reset was not released in time");
			$display("Testbench failed");
			$fatal(1, "reset timeout");
		end
		forever begin
			@(posedge clk);
			exp_valid = active;
			if (active) begin
				exp = expected_entry();
			end
			update_shadow();
			@(negedge clk);
			if (exp_valid) begin
				compare_entry(exp);
				checks_done++;
			end
		end
	end

	initial begin : main_proc
		int wait_cycles;
		rng_state = 32'd5;
		active = 1'b0;
		for (int i = 0; i < 32; i++) begin
			shadow_regs[i] = 32'd0;
		end
		shadow_lr = 32'd0;
		shadow_fl = 2'd0;
		set_idle();
		rst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// state left by reset
		compare_entry(ref_nop());
		for (int i = 0; i < NUM_INSTR; i++) begin
			@(negedge clk);
			drive_random(i);
			active = 1'b1;
		end
		@(negedge clk);
		set_idle();
		active = 1'b0;
		wait_cycles = 0;
		while (checks_done < NUM_INSTR && wait_cycles < 20) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (checks_done == NUM_INSTR) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("only %0d of %0d entries were compared", checks_done, NUM_INSTR);
			$display("Testbench failed");
			$fatal(1, "comparison timeout");
		end
	end

endmodule

// File: compile.f
+incdir+tb
rtl/isa_pkg.sv
rtl/reg_file_bypass.sv
rtl/special_regs.sv
rtl/control_decoder.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
tb/tb_decode_stage.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f compile.f --top-module tb_decode_stage || exit 1
out=$(./obj_dir/Vtb_decode_stage 2>&1)
echo "$out"
echo "$out" | grep -q "^Testbench passed$" && exit 0 || exit 1
